/* verilog/adcPkg.sv */
package adcPkg;

	// ********************
	// timing
	// ********************

	// clkEn pulses between filter sample ticks.
	localparam int SAMPLE_PRESCALE = 256;
	// equal samples needed before a filter is ready.
	localparam int DEBOUNCE_COUNT = 4;

	// ********************
	// data types
	// ********************

	typedef logic [11:0] adcSample_t;
	typedef logic [7:0] adcByte_t;
	typedef logic [1:0] fireBits_t;

	// converted values for the three axis positions.
	localparam adcSample_t SAMPLE_LOW = 12'h000;
	localparam adcSample_t SAMPLE_CENTRE = 12'h800;
	localparam adcSample_t SAMPLE_HIGH = 12'hFFF;

	// axis state from an active-low switch pair.
	typedef enum logic [1:0] {
		dirCentre = 2'd0,
		dirLow = 2'd1,
		dirHigh = 2'd2
	} stickDir_t;

	// host register map, addresses 2 and 3 both select the low byte.
	typedef enum logic [1:0] {
		regStatus = 2'd0,
		regHigh = 2'd1,
		regLow = 2'd2
	} busReg_t;

	typedef enum logic [1:0] {
		convIdle = 2'd0,
		convFilling = 2'd1,
		convOffering = 2'd2
	} convState_t;

endpackage

/* verilog/debounceFilter.sv */
`timescale 1ns/1ps

module debounceFilter
	import adcPkg::*;
#(
	parameter int WIDTH = 1,
	parameter logic [WIDTH-1:0] PRESET = '1
) (
	input logic CLK,
	input logic nRESET,
	input logic sampleTick,
	input logic restart,
	input logic [WIDTH-1:0] rawIn,
	output logic [WIDTH-1:0] filtered,
	output logic ready
);

	localparam int COUNT_W = $clog2(DEBOUNCE_COUNT + 1);

	logic [WIDTH-1:0] lastSample;
	logic [COUNT_W-1:0] stableCount;
	logic countDone;
	logic countNearDone;

	assign countDone = (stableCount == COUNT_W'(DEBOUNCE_COUNT));
	assign countNearDone = (stableCount == COUNT_W'(DEBOUNCE_COUNT - 1));

	// count equal samples, a change starts the run again.
	always_ff @(posedge CLK or negedge nRESET) begin
		if (!nRESET) begin
			lastSample <= PRESET;
			stableCount <= '0;
			filtered <= PRESET;
			ready <= 1'b0;
		end else if (restart) begin
			lastSample <= PRESET;
			stableCount <= '0;
			filtered <= PRESET;
			ready <= 1'b0;
		end else if (sampleTick) begin
			if (rawIn == lastSample) begin
				if (!countDone) begin
					stableCount <= stableCount + 1'b1;
				end
				// stable long enough.
				if (countNearDone || countDone) begin
					filtered <= rawIn;
					ready <= 1'b1;
				end
			end else begin
				lastSample <= rawIn;
				stableCount <= '0;
			end
		end
	end

endmodule

/* verilog/stickSampler.sv */
`timescale 1ns/1ps

module stickSampler
	import adcPkg::*;
(
	input logic CLK,
	input logic nRESET,
	input logic clkEn,
	input logic [3:0] stick,
	input logic [1:0] fire,
	input logic filterRestart,
	output logic [1:0] axisX,
	output logic [1:0] axisY,
	output logic axisReadyX,
	output logic axisReadyY,
	output fireBits_t fireOut
);

	localparam int PRESCALE_W = $clog2(SAMPLE_PRESCALE);

	logic [3:0] stickMeta;
	logic [3:0] stickSync;
	logic [1:0] fireMeta;
	logic [1:0] fireSync;
	logic [PRESCALE_W-1:0] prescale;
	logic prescaleLast;
	logic sampleTick;

	// ********************
	// input synchronisers
	// ********************

	// switches read as open until synchronised.
	always_ff @(posedge CLK or negedge nRESET) begin
		if (!nRESET) begin
			stickMeta <= '1;
			stickSync <= '1;
			fireMeta <= '1;
			fireSync <= '1;
		end else begin
			stickMeta <= stick;
			stickSync <= stickMeta;
			fireMeta <= fire;
			fireSync <= fireMeta;
		end
	end

	// ********************
	// sample prescaler
	// ********************

	assign prescaleLast = (prescale == PRESCALE_W'(SAMPLE_PRESCALE - 1));
	assign sampleTick = clkEn && prescaleLast;

	always_ff @(posedge CLK or negedge nRESET) begin
		if (!nRESET) begin
			prescale <= '0;
		end else if (clkEn) begin
			prescale <= prescaleLast ? '0 : prescale + 1'b1;
		end
	end

	// axis filters restart with each conversion.
	debounceFilter #(.WIDTH(2), .PRESET(2'b11)) filterX (
		.CLK(CLK),
		.nRESET(nRESET),
		.sampleTick(sampleTick),
		.restart(filterRestart),
		.rawIn(stickSync[1:0]),
		.filtered(axisX),
		.ready(axisReadyX)
	);

	debounceFilter #(.WIDTH(2), .PRESET(2'b11)) filterY (
		.CLK(CLK),
		.nRESET(nRESET),
		.sampleTick(sampleTick),
		.restart(filterRestart),
		.rawIn(stickSync[3:2]),
		.filtered(axisY),
		.ready(axisReadyY)
	);

	// fire buttons run freely.
	debounceFilter #(.WIDTH(1), .PRESET(1'b1)) filterFire0 (
		.CLK(CLK),
		.nRESET(nRESET),
		.sampleTick(sampleTick),
		.restart(1'b0),
		.rawIn(fireSync[0]),
		.filtered(fireOut[0]),
		.ready()
	);

	debounceFilter #(.WIDTH(1), .PRESET(1'b1)) filterFire1 (
		.CLK(CLK),
		.nRESET(nRESET),
		.sampleTick(sampleTick),
		.restart(1'b0),
		.rawIn(fireSync[1]),
		.filtered(fireOut[1]),
		.ready()
	);

endmodule

/* verilog/conversionSequencer.sv */
`timescale 1ns/1ps

module conversionSequencer
	import adcPkg::*;
(
	input logic CLK,
	input logic nRESET,
	input logic convStart,
	input logic [1:0] convChannel,
	input logic [1:0] axisX,
	input logic [1:0] axisY,
	input logic axisReadyX,
	input logic axisReadyY,
	input logic resultReady,
	output logic filterRestart,
	output logic resultValid,
	output adcSample_t resultSample
);

	convState_t state;
	logic selectY;
	logic [1:0] selPair;
	logic selReady;
	stickDir_t selDir;

	// switches are active low.
	function automatic stickDir_t decodeDir(input logic [1:0] pair);
		case (pair)
			2'b01: decodeDir = dirLow;
			2'b10: decodeDir = dirHigh;
			default: decodeDir = dirCentre;
		endcase
	endfunction

	function automatic adcSample_t dirToSample(input stickDir_t dir);
		case (dir)
			dirLow: dirToSample = SAMPLE_LOW;
			dirHigh: dirToSample = SAMPLE_HIGH;
			default: dirToSample = SAMPLE_CENTRE;
		endcase
	endfunction

	assign selPair = selectY ? axisY : axisX;
	assign selReady = selectY ? axisReadyY : axisReadyX;
	assign selDir = decodeDir(selPair);
	assign resultValid = (state == convOffering);

	// ********************
	// conversion FSM
	// ********************

	always_ff @(posedge CLK or negedge nRESET) begin
		if (!nRESET) begin
			state <= convIdle;
			selectY <= 1'b0;
			filterRestart <= 1'b0;
		end else begin
			filterRestart <= 1'b0;
			if (convStart) begin
				// odd channels read the Y pair.
				selectY <= convChannel[0];
				filterRestart <= 1'b1;
				state <= convFilling;
			end else begin
				case (state)
					convFilling: begin
						// ready is stale until the restart has landed.
						if (!filterRestart && selReady) begin
							state <= convOffering;
						end
					end
					convOffering: begin
						if (resultReady) begin
							state <= convIdle;
						end
					end
					default: state <= convIdle;
				endcase
			end
		end
	end

	// held until the transfer.
	always_ff @(posedge CLK) begin
		if (state == convFilling && !filterRestart && selReady) begin
			resultSample <= dirToSample(selDir);
		end
	end

endmodule

/* verilog/hostRegisters.sv */
`timescale 1ns/1ps

module hostRegisters
	import adcPkg::*;
(
	input logic CLK,
	input logic nRESET,
	input logic clkEn,
	input logic nCS,
	input logic RnW,
	input logic [1:0] addr,
	input adcByte_t dataIn,
	input logic resultValid,
	input adcSample_t resultSample,
	output logic resultReady,
	output logic convStart,
	output logic [1:0] convChannel,
	output adcByte_t dataOut,
	output logic dataOutEnable,
	output logic nEOC
);

	logic [3:0] status;
	adcSample_t resultReg;
	busReg_t regSel;
	logic statusWrite;
	logic transfer;

	// addresses 2 and 3 alias.
	assign regSel = addr[1] ? regLow : busReg_t'(addr);

	assign statusWrite = clkEn && !nCS && !RnW && (regSel == regStatus);
	assign transfer = resultValid && resultReady;

	// a new start drops any pending result.
	assign resultReady = !statusWrite;
	assign convStart = statusWrite;
	assign convChannel = dataIn[1:0];

	assign dataOutEnable = !nCS && RnW;

	always_ff @(posedge CLK or negedge nRESET) begin
		if (!nRESET) begin
			status <= '0;
			nEOC <= 1'b1;
		end else if (statusWrite) begin
			status <= dataIn[3:0];
			nEOC <= 1'b1;
		end else if (transfer) begin
			nEOC <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (transfer) begin
			resultReg <= resultSample;
		end
	end

	// ********************
	// read mux
	// ********************

	always_comb begin
		case (regSel)
			regStatus: dataOut = {nEOC, !nEOC, resultReg[11:10], status};
			regHigh: dataOut = resultReg[11:4];
			default: dataOut = {resultReg[3:0], 4'h0};
		endcase
	end

endmodule

/* verilog/adcJoystick.sv */
`timescale 1ns/1ps

module adcJoystick
	import adcPkg::*;
(
	input logic CLK,
	input logic nRESET,
	input logic clkEn,
	input logic nCS,
	input logic RnW,
	input logic [1:0] addr,
	input adcByte_t dataIn,
	input logic [3:0] stick,
	input logic [1:0] fire,
	output adcByte_t dataOut,
	output logic dataOutEnable,
	output logic nEOC,
	output fireBits_t fireOut
);

	logic convStart;
	logic [1:0] convChannel;
	logic filterRestart;
	logic [1:0] axisX;
	logic [1:0] axisY;
	logic axisReadyX;
	logic axisReadyY;
	logic resultValid;
	logic resultReady;
	adcSample_t resultSample;

	stickSampler sampler (
		.CLK(CLK),
		.nRESET(nRESET),
		.clkEn(clkEn),
		.stick(stick),
		.fire(fire),
		.filterRestart(filterRestart),
		.axisX(axisX),
		.axisY(axisY),
		.axisReadyX(axisReadyX),
		.axisReadyY(axisReadyY),
		.fireOut(fireOut)
	);

	conversionSequencer sequencer (
		.CLK(CLK),
		.nRESET(nRESET),
		.convStart(convStart),
		.convChannel(convChannel),
		.axisX(axisX),
		.axisY(axisY),
		.axisReadyX(axisReadyX),
		.axisReadyY(axisReadyY),
		.resultReady(resultReady),
		.filterRestart(filterRestart),
		.resultValid(resultValid),
		.resultSample(resultSample)
	);

	hostRegisters registers (
		.CLK(CLK),
		.nRESET(nRESET),
		.clkEn(clkEn),
		.nCS(nCS),
		.RnW(RnW),
		.addr(addr),
		.dataIn(dataIn),
		.resultValid(resultValid),
		.resultSample(resultSample),
		.resultReady(resultReady),
		.convStart(convStart),
		.convChannel(convChannel),
		.dataOut(dataOut),
		.dataOutEnable(dataOutEnable),
		.nEOC(nEOC)
	);

endmodule

/* test/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
	output logic CLK,
	output logic nRESET
);

	localparam int RESET_CYCLES = 8;

	// 10 ns period.
	initial begin
		CLK = 1'b0;
		forever begin
			#5 CLK = !CLK;
		end
	end

	initial begin
		nRESET = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		nRESET <= 1'b1;
	end

endmodule

/* test/adcJoystick_assertions.sv */
`timescale 1ns/1ps

module adcJoystick_assertions
	import adcPkg::*;
(
	input logic CLK,
	input logic nRESET,
	input logic nCS,
	input logic RnW,
	input logic dataOutEnable,
	input logic convStart,
	input logic resultValid,
	input logic resultReady,
	input adcSample_t resultSample,
	input logic nEOC
);

	int failCount = 0;

	// bus driven only for a selected read.
	readEnable: assert property (@(posedge CLK) disable iff (!nRESET)
		dataOutEnable == (!nCS && RnW))
		else begin
			failCount++;
			$error("dataOutEnable does not follow nCS and RnW");
		end

	// a held result keeps its value.
	sampleHeld: assert property (@(posedge CLK) disable iff (!nRESET)
		resultValid && !resultReady |=> $stable(resultSample))
		else begin
			failCount++;
			$error("resultSample changed while the result was held");
		end

	startRaisesEoc: assert property (@(posedge CLK) disable iff (!nRESET)
		convStart |=> nEOC)
		else begin
			failCount++;
			$error("nEOC not high in the cycle after a conversion start");
		end

endmodule

/* test/adcJoystickTb.sv */
`timescale 1ns/1ps

module adcJoystickTb
	import adcPkg::*;
();

	localparam int TICK_CYCLES = SAMPLE_PRESCALE;
	localparam int EOC_BOUND = (DEBOUNCE_COUNT + 2) * SAMPLE_PRESCALE + 16;
	localparam int FIRE_BOUND = (DEBOUNCE_COUNT + 1) * SAMPLE_PRESCALE + 4;
	localparam int NUM_CONV = 20;
	localparam int WATCHDOG_CYCLES = NUM_CONV * EOC_BOUND + 4 * FIRE_BOUND + 4096;

	logic CLK;
	logic nRESET;
	logic clkEn;
	logic nCS;
	logic RnW;
	logic [1:0] addr;
	adcByte_t dataIn;
	logic [3:0] stick;
	logic [1:0] fire;
	adcByte_t dataOut;
	logic dataOutEnable;
	logic nEOC;
	fireBits_t fireOut;

	int errorCount = 0;
	int checkCount = 0;
	logic [31:0] rngState = 32'h7ed640df;

	clockGen clocks (.CLK(CLK), .nRESET(nRESET));

	adcJoystick dut (.*);

	bind adcJoystick adcJoystick_assertions checks (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// switches are active low so 01 pulls the axis low.
	function automatic adcByte_t expectedHigh(input logic [1:0] pair);
		case (pair)
			2'b01: return 8'h00;
			2'b10: return 8'hFF;
			default: return 8'h80;
		endcase
	endfunction

	// only the high end sets the low nibble.
	function automatic adcByte_t expectedLow(input logic [1:0] pair);
		return (pair == 2'b10) ? 8'hF0 : 8'h00;
	endfunction

	// ********************
	// compare tasks
	// ********************

	task automatic checkByte(input string name, input adcByte_t got, input adcByte_t exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("** Error %s: got 0x%02h, expected 0x%02h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkFire(input fireBits_t got, input fireBits_t exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("** Error fireOut: got 0x%01h, expected 0x%01h at %0t", got, exp, $time);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("** Error %s: got 0x%01h, expected 0x%01h at %0t", name, got, exp, $time);
		end
	endtask

	// ********************
	// bus tasks
	// ********************

	task automatic hostWrite(input logic [1:0] a, input adcByte_t d);
		@(posedge CLK);
		nCS <= 1'b0;
		RnW <= 1'b0;
		addr <= a;
		dataIn <= d;
		@(negedge CLK);
		checkFlag("dataOutEnable", dataOutEnable, 1'b0);
		@(posedge CLK);
		nCS <= 1'b1;
		RnW <= 1'b1;
	endtask

	task automatic hostRead(input logic [1:0] a, output adcByte_t d);
		@(posedge CLK);
		nCS <= 1'b0;
		RnW <= 1'b1;
		addr <= a;
		@(negedge CLK);
		d = dataOut;
		checkFlag("dataOutEnable", dataOutEnable, 1'b1);
		@(posedge CLK);
		nCS <= 1'b1;
	endtask

	task automatic waitEoc(output logic done);
		int cycles;
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < EOC_BOUND) begin
			@(negedge CLK);
			done = !nEOC;
			cycles++;
		end
		if (!done) begin
			errorCount++;
			$display("conversion never ended, nEOC stayed high for %0d cycles", EOC_BOUND);
		end
	endtask

	task automatic waitFire(input fireBits_t exp);
		int cycles;
		cycles = 0;
		while (fireOut !== exp && cycles < FIRE_BOUND) begin
			@(negedge CLK);
			cycles++;
		end
		checkFire(fireOut, exp);
	endtask

	task automatic readResult(input logic [3:0] statusVal, input logic [1:0] pair);
		adcByte_t value;
		adcByte_t expHigh;
		expHigh = expectedHigh(pair);
		hostRead(2'd0, value);
		checkByte("dataOut (status)", value, {2'b01, expHigh[7:6], statusVal});
		hostRead(2'd1, value);
		checkByte("dataOut (high)", value, expHigh);
		rngState = xorshift(rngState);
		hostRead({1'b1, rngState[4]}, value);
		checkByte("dataOut (low)", value, expectedLow(pair));
	endtask

	task automatic runConversion(input logic [1:0] channel, input logic [1:0] pair);
		logic [3:0] statusVal;
		logic done;
		rngState = xorshift(rngState);
		statusVal = {rngState[3:2], channel};
		@(posedge CLK);
		stick <= channel[0] ? {pair, rngState[1:0]} : {rngState[1:0], pair};
		repeat (3) @(posedge CLK);
		hostWrite(2'd0, {rngState[7:4], statusVal});
		waitEoc(done);
		if (done) begin
			readResult(statusVal, pair);
		end
	endtask

	// ********************
	// tests
	// ********************

	task automatic resetTest();
		adcByte_t value;
		checkFlag("nEOC", nEOC, 1'b1);
		checkFire(fireOut, 2'b11);
		hostRead(2'd0, value);
		checkFlag("dataOut[7]", value[7], 1'b1);
		checkFlag("dataOut[6]", value[6], 1'b0);
	endtask

	// every channel and pattern in shuffled order.
	task automatic conversionTest();
		logic [3:0] order [16];
		logic [3:0] swap;
		int pick;
		for (int i = 0; i < 16; i++) begin
			order[i] = 4'(i);
		end
		for (int i = 15; i > 0; i--) begin
			rngState = xorshift(rngState);
			pick = int'(rngState[7:0]) % (i + 1);
			swap = order[i];
			order[i] = order[pick];
			order[pick] = swap;
		end
		for (int i = 0; i < 16; i++) begin
			runConversion(order[i][3:2], order[i][1:0]);
		end
	endtask

	task automatic rewriteTest();
		logic done;
		@(posedge CLK);
		stick <= 4'b0110;
		repeat (3) @(posedge CLK);
		hostWrite(2'd0, 8'h00);
		repeat (300) @(posedge CLK);
		@(negedge CLK);
		checkFlag("nEOC", nEOC, 1'b1);
		hostWrite(2'd0, 8'h01);
		@(negedge CLK);
		checkFlag("nEOC", nEOC, 1'b1);
		waitEoc(done);
		if (done) begin
			readResult(4'h1, 2'b01);
		end
	endtask

	// X switch bounces faster than a sample tick and settles at 10.
	task automatic bounceTest();
		logic done;
		@(posedge CLK);
		stick <= 4'b1110;
		repeat (3) @(posedge CLK);
		hostWrite(2'd0, 8'h02);
		for (int i = 0; i < 6; i++) begin
			repeat (100) @(posedge CLK);
			stick[0] <= !stick[0];
		end
		@(negedge CLK);
		checkFlag("nEOC", nEOC, 1'b1);
		waitEoc(done);
		if (done) begin
			readResult(4'h2, 2'b10);
		end
	endtask

	task automatic readEnableTest();
		@(negedge CLK);
		checkFlag("dataOutEnable", dataOutEnable, 1'b0);
		hostWrite(2'd1, 8'hA5);
		hostWrite(2'd3, 8'h5A);
		// status write without chip select.
		@(posedge CLK);
		RnW <= 1'b0;
		addr <= 2'd0;
		dataIn <= 8'h03;
		@(negedge CLK);
		checkFlag("dataOutEnable", dataOutEnable, 1'b0);
		@(posedge CLK);
		RnW <= 1'b1;
		@(negedge CLK);
		checkFlag("nEOC", nEOC, 1'b0);
		readResult(4'h2, 2'b10);
	endtask

	task automatic fireTest();
		fireBits_t fireSeen;
		// first value other than 11 seen on fireOut.
		fireSeen = 2'b11;
		@(posedge CLK);
		fire <= 2'b10;
		repeat (TICK_CYCLES / 2) @(posedge CLK);
		fire <= 2'b11;
		repeat ((DEBOUNCE_COUNT + 2) * TICK_CYCLES) begin
			@(negedge CLK);
			if (fireOut !== 2'b11 && fireSeen === 2'b11) begin
				fireSeen = fireOut;
			end
		end
		checkFire(fireSeen, 2'b11);
		@(posedge CLK);
		fire <= 2'b01;
		waitFire(2'b01);
		@(posedge CLK);
		fire <= 2'b11;
		waitFire(2'b11);
	endtask

	initial begin
		clkEn = 1'b1;
		nCS = 1'b1;
		RnW = 1'b1;
		addr = 2'd0;
		dataIn = '0;
		stick = 4'hF;
		fire = 2'b11;
		wait (nRESET === 1'b1);
		@(negedge CLK);
		resetTest();
		conversionTest();
		rewriteTest();
		bounceTest();
		readEnableTest();
		fireTest();
		$display("checks: %0d, errors: %0d, assertion failures: %0d",
			checkCount, errorCount, dut.checks.failCount);
		if (errorCount == 0 && dut.checks.failCount == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* adcJoystick.f */
verilog/adcPkg.sv
verilog/debounceFilter.sv
verilog/stickSampler.sv
verilog/conversionSequencer.sv
verilog/hostRegisters.sv
verilog/adcJoystick.sv
test/clockGen.sv
test/adcJoystick_assertions.sv
test/adcJoystickTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= adcJoystickTb
FILELIST ?= adcJoystick.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIM_ARGS ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
